//--- common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Instruction memory words, addressed by the 6-bit pc
`define IMEM_DEPTH 64

// Data memory words
`define DMEM_DEPTH 32

// Queue entries, also the credits held by fetch after reset
`define QUEUE_DEPTH 4

// Architectural registers
`define REG_COUNT 16

`endif

//--- common/cpu_pkg.sv
package cpu_pkg;

   typedef enum logic [3:0] {
      OP_LDI  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_LD   = 4'h6,
      OP_ST   = 4'h7,
      OP_HALT = 4'h8
   } opcode_t;

   // Bits 31:28 opcode, 27:24 rd, 23:20 rs1, 19:16 rs2, 15:0 imm
   typedef struct packed {
      opcode_t     opcode;
      logic [3:0]  rd;
      logic [3:0]  rs1;
      logic [3:0]  rs2;
      logic [15:0] imm;
   } instr_t;

   // One queue entry
   typedef struct packed {
      instr_t     instr;
      logic [5:0] pc;
   } fetch_item_t;

   // Register write-back report
   typedef struct packed {
      logic [3:0]  rd;
      logic [31:0] data;
   } wb_t;

endpackage

//--- execute/register_file.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module register_file (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [3:0]  read_address_0,
   input  logic [3:0]  read_address_1,
   output logic [31:0] read_data_0,
   output logic [31:0] read_data_1,
   input  logic [3:0]  write_address,
   input  logic [31:0] write_data,
   input  logic        write_enable
);

   logic [31:0] regs [`REG_COUNT];

   // Reads are combinational
   assign read_data_0 = regs[read_address_0];
   assign read_data_1 = regs[read_address_1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable) begin
         regs[write_address] <= write_data;
      end
   end

endmodule

//--- execute/execute_unit.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module execute_unit (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 head_valid,
   input  cpu_pkg::fetch_item_t head_item,
   output logic                 pop,
   output logic                 wb_valid,
   output cpu_pkg::wb_t         wb,
   output logic                 halted
);

   localparam int dmem_aw = $clog2(`DMEM_DEPTH);

   typedef enum logic [1:0] {
      STAGE_IDLE,
      STAGE_DECODE,
      STAGE_EXECUTE,
      STAGE_WRITEBACK
   } stage_t;

   stage_t               stage;
   cpu_pkg::fetch_item_t current;
   cpu_pkg::opcode_t     opcode;
   logic [31:0]          op_a;
   logic [31:0]          op_b;
   logic [31:0]          imm_ext;
   logic [31:0]          addr_sum;
   logic [dmem_aw-1:0]   dmem_addr;
   logic [31:0]          result;
   logic [31:0]          read_data_0;
   logic [31:0]          read_data_1;
   logic                 writes_reg;
   logic                 reg_write;
   logic [31:0]          dmem [`DMEM_DEPTH];

   assign opcode    = current.instr.opcode;
   assign imm_ext   = {16'h0000, current.instr.imm};
   assign addr_sum  = op_a + imm_ext;
   assign dmem_addr = addr_sum[dmem_aw-1:0];

   assign writes_reg = (opcode != cpu_pkg::OP_ST) && (opcode != cpu_pkg::OP_HALT);

   assign pop       = (stage == STAGE_IDLE) && head_valid && !halted;
   assign reg_write = (stage == STAGE_WRITEBACK) && writes_reg;
   assign wb_valid  = reg_write;
   assign wb.rd     = current.instr.rd;
   assign wb.data   = result;

   // Operand indexes come straight from the latched instruction
   register_file reg_file (
      .clk            (clk),
      .rst_n          (rst_n),
      .read_address_0 (current.instr.rs1),
      .read_address_1 (current.instr.rs2),
      .read_data_0    (read_data_0),
      .read_data_1    (read_data_1),
      .write_address  (current.instr.rd),
      .write_data     (result),
      .write_enable   (reg_write)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage  <= STAGE_IDLE;
         halted <= 1'b0;
      end else begin
         case (stage)
            STAGE_IDLE:    stage <= pop ? STAGE_DECODE : STAGE_IDLE;
            STAGE_DECODE:  stage <= STAGE_EXECUTE;
            STAGE_EXECUTE: stage <= STAGE_WRITEBACK;
            default:       stage <= STAGE_IDLE;
         endcase
         if (stage == STAGE_WRITEBACK && opcode == cpu_pkg::OP_HALT) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         current <= head_item;
      end
      if (stage == STAGE_DECODE) begin
         op_a <= read_data_0;
         op_b <= read_data_1;
      end
      if (stage == STAGE_EXECUTE) begin
         case (opcode)
            cpu_pkg::OP_LDI: result <= imm_ext;
            cpu_pkg::OP_ADD: result <= op_a + op_b;
            cpu_pkg::OP_SUB: result <= op_a - op_b;
            cpu_pkg::OP_AND: result <= op_a & op_b;
            cpu_pkg::OP_OR:  result <= op_a | op_b;
            cpu_pkg::OP_XOR: result <= op_a ^ op_b;
            cpu_pkg::OP_LD:  result <= dmem[dmem_addr];
            default:         result <= '0;
         endcase
         if (opcode == cpu_pkg::OP_ST) begin
            dmem[dmem_addr] <= op_b;
         end
      end
   end

endmodule

//--- fetch/fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetch_unit (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 load_en,
   input  logic [5:0]           load_addr,
   input  cpu_pkg::instr_t      load_instr,
   input  logic                 start,
   input  logic                 credit_return,
   output logic                 push,
   output cpu_pkg::fetch_item_t push_item
);

   localparam int credit_w = $clog2(`QUEUE_DEPTH + 1);
   localparam logic [5:0] last_pc = 6'(`IMEM_DEPTH - 1);

   cpu_pkg::instr_t imem [`IMEM_DEPTH];

   logic [5:0]          pc;
   logic                running;
   logic [credit_w-1:0] credits;
   logic                pushing_halt;
   logic                fetch_fire;

   // A HALT on its way out blocks the read behind it
   assign pushing_halt = push && (push_item.instr.opcode == cpu_pkg::OP_HALT);
   assign fetch_fire   = running && (credits != '0) && !pushing_halt;

   always_ff @(posedge clk) begin
      if (load_en && !running) begin
         imem[load_addr] <= load_instr;
      end
      if (fetch_fire) begin
         push_item.instr <= imem[pc];
         push_item.pc    <= pc;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc      <= '0;
         running <= 1'b0;
         push    <= 1'b0;
      end else begin
         push <= fetch_fire;
         if (start && !running) begin
            pc      <= '0;
            running <= 1'b1;
         end else begin
            if (fetch_fire) begin
               pc <= pc + 6'd1;
            end
            if ((fetch_fire && pc == last_pc) || pushing_halt) begin
               running <= 1'b0;
            end
         end
      end
   end

   // Credit is taken when the read issues, one cycle ahead of its push
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= credit_w'(`QUEUE_DEPTH);
      end else begin
         case ({fetch_fire, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

//--- logic/instr_queue.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module instr_queue #(
   parameter type payload_t = cpu_pkg::fetch_item_t,
   parameter int  depth     = `QUEUE_DEPTH
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_item,
   input  logic     pop,
   output logic     head_valid,
   output payload_t head_item,
   output logic     credit_return
);

   localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
   localparam int count_w = $clog2(depth + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

   payload_t buffer [depth];

   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic [count_w-1:0] count;
   logic               pop_ok;

   assign head_valid = (count != '0);
   assign head_item  = buffer[rd_ptr];
   assign pop_ok     = pop && head_valid;

   // No full check, the sender never pushes without credit
   always_ff @(posedge clk) begin
      if (push) begin
         buffer[wr_ptr] <= push_item;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         credit_return <= pop_ok;
         if (push) begin
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_top (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            load_en,
   input  logic [5:0]      load_addr,
   input  cpu_pkg::instr_t load_instr,
   input  logic            start,
   output logic            wb_valid,
   output cpu_pkg::wb_t    wb,
   output logic            halted
);

   logic                 push;
   cpu_pkg::fetch_item_t push_item;
   logic                 credit_return;
   logic                 pop;
   logic                 head_valid;
   cpu_pkg::fetch_item_t head_item;

   fetch_unit fetch (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_en       (load_en),
      .load_addr     (load_addr),
      .load_instr    (load_instr),
      .start         (start),
      .credit_return (credit_return),
      .push          (push),
      .push_item     (push_item)
   );

   instr_queue #(
      .payload_t (cpu_pkg::fetch_item_t),
      .depth     (`QUEUE_DEPTH)
   ) queue (
      .clk           (clk),
      .rst_n         (rst_n),
      .push          (push),
      .push_item     (push_item),
      .pop           (pop),
      .head_valid    (head_valid),
      .head_item     (head_item),
      .credit_return (credit_return)
   );

   execute_unit execute (
      .clk        (clk),
      .rst_n      (rst_n),
      .head_valid (head_valid),
      .head_item  (head_item),
      .pop        (pop),
      .wb_valid   (wb_valid),
      .wb         (wb),
      .halted     (halted)
   );

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_tb;

   localparam int clk_half      = 20;
   localparam int settle_cycles = 20;

   logic            clk;
   logic            rst_n;
   logic            load_en;
   logic [5:0]      load_addr;
   cpu_pkg::instr_t load_instr;
   logic            start;
   logic            wb_valid;
   cpu_pkg::wb_t    wb;
   logic            halted;

   // Word count, program, write-back count, then rd and data pairs
   logic [31:0] stim [0:127];
   int          word_count;
   int          exp_count;
   int          timeout_limit;
   int          halt_pc;
   int          wb_pc [$];
   int          wb_seen = 0;
   int          cycle = 0;
   int          start_cycle = 0;
   bit          started = 1'b0;
   bit          halted_seen = 1'b0;

   cpu_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_instr (load_instr),
      .start      (start),
      .wb_valid   (wb_valid),
      .wb         (wb),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // One instruction retires every 4 cycles, first write-back 6 cycles after start
   task automatic check_writeback();
      int          base;
      int          exp_cycle;
      logic [3:0]  exp_rd;
      logic [31:0] exp_data;
      assert (!halted_seen)
         else report_failure("A write-back appeared after halt");
      assert (wb_seen < exp_count)
         else report_failure("More write-backs appeared than the stim file expects");
      base      = word_count + 2 + 2 * wb_seen;
      exp_rd    = stim[base][3:0];
      exp_data  = stim[base + 1];
      exp_cycle = start_cycle + 6 + 4 * wb_pc[wb_seen];
      assert (wb.rd == exp_rd)
         else report_failure($sformatf("Error test=wb%0d_reg expected=%0h actual=%0h",
                                       wb_seen, exp_rd, wb.rd));
      assert (wb.data == exp_data)
         else report_failure($sformatf("Error test=wb%0d_data expected=%h actual=%h",
                                       wb_seen, exp_data, wb.data));
      assert (cycle == exp_cycle)
         else report_failure($sformatf("Error test=wb%0d_timing expected=%0d actual=%0d",
                                       wb_seen, exp_cycle - start_cycle,
                                       cycle - start_cycle));
      wb_seen++;
   endtask

   // Outputs are sampled half a cycle after the driving edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (start && !started) begin
            started     = 1'b1;
            start_cycle = cycle;
         end
         if (wb_valid) begin
            check_writeback();
         end
         if (halted_seen) begin
            assert (halted)
               else report_failure("halted dropped after it was set");
         end else if (halted) begin
            halted_seen = 1'b1;
            assert (cycle == start_cycle + 7 + 4 * halt_pc)
               else report_failure($sformatf("Error test=halt_timing expected=%0d actual=%0d",
                                             7 + 4 * halt_pc, cycle - start_cycle));
         end
         if (started && !halted_seen && (cycle - start_cycle > timeout_limit)) begin
            report_failure("Timeout: halted never arrived after start");
         end
      end
   end

   initial begin
      rst_n      = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_instr = '0;
      start      = 1'b0;
      halt_pc    = -1;

      $readmemh("verification/cpu_stim.txt", stim);
      word_count    = stim[0];
      exp_count     = stim[word_count + 1];
      timeout_limit = 4 * word_count + 6 + 50;

      // Register-writing instructions in program order, up to HALT
      for (int i = 0; i < word_count; i++) begin
         if (halt_pc < 0) begin
            if (stim[1 + i][31:28] == cpu_pkg::OP_HALT) begin
               halt_pc = i;
            end else if (stim[1 + i][31:28] != cpu_pkg::OP_ST) begin
               wb_pc.push_back(i);
            end
         end
      end
      assert (halt_pc >= 0)
         else report_failure("The stim program holds no HALT");
      assert (word_count > `QUEUE_DEPTH)
         else report_failure("The stim program is too short to fill the queue");
      assert (wb_pc.size() == exp_count)
         else report_failure("The stim write-back count does not match the program");

      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (!halted && !wb_valid)
         else report_failure("Outputs were not idle after reset");

      for (int i = 0; i < word_count; i++) begin
         @(posedge clk);
         load_en    <= 1'b1;
         load_addr  <= 6'(i);
         load_instr <= cpu_pkg::instr_t'(stim[1 + i]);
      end
      @(posedge clk);
      load_en <= 1'b0;
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;

      wait (halted_seen);
      repeat (settle_cycles) @(posedge clk);
      @(negedge clk);
      assert (wb_seen == exp_count)
         else report_failure($sformatf("Error test=writeback_count expected=%0d actual=%0d",
                                       exp_count, wb_seen));
      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- verification/cpu_stim.txt
// Word count, program words, write-back count, then one rd and data pair per write-back
// Program: LDI x3, ADD, SUB, AND, OR, XOR, ST, LD, ADD, HALT
0000000C
01000005
02000009
0300F0F0
14120000
25120000
36530000
47130000
58530000
7017001D
69200019
1A940000
80000000
0000000A
1 00000005
2 00000009
3 0000F0F0
4 0000000E
5 FFFFFFFC
6 0000F0F0
7 0000F0F5
8 FFFF0F0C
9 0000F0F5
A 0000F103

//--- cpu.f
+incdir+common
common/cpu_pkg.sv
execute/register_file.sv
execute/execute_unit.sv
fetch/fetch_unit.sv
logic/instr_queue.sv
logic/cpu_top.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f -o cpu_sim &&
out="$(./obj_dir/cpu_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
